/* dv/gpio_test_table.svh */
// Rows run in order from reset; a write row's expected word is the register content it should leave
// Each row gives name, operation, offset, write data, expected word and bready delay in cycles

// Tristate reset values
add_row("reset tri read",       OP_READ,  8'h04, 32'h0000_0000, 32'hFFFF_FFFF, 0);
add_row("reset tri2 read",      OP_READ,  8'h0C, 32'h0000_0000, 32'hFFFF_FFFF, 0);

// Output data registers
add_row("data write",           OP_WRITE, 8'h00, 32'h1234_5678, 32'h1234_5678, 0);
add_row("data2 write",          OP_WRITE, 8'h08, 32'hCAFE_0001, 32'hCAFE_0001, 0);

// Tristate registers with read back
add_row("tri write",            OP_WRITE, 8'h04, 32'h0000_FFFF, 32'h0000_FFFF, 0);
add_row("tri read back",        OP_READ,  8'h04, 32'h0000_0000, 32'h0000_FFFF, 0);
add_row("tri2 write",           OP_WRITE, 8'h0C, 32'h00FF_00FF, 32'h00FF_00FF, 0);
add_row("tri2 read back",       OP_READ,  8'h0C, 32'h0000_0000, 32'h00FF_00FF, 0);

// Sampled inputs
add_row("input read",           OP_READ,  8'h00, 32'h0000_0000, GPIO1_PATTERN, 0);
add_row("input2 read",          OP_READ,  8'h08, 32'h0000_0000, gpio2_val, 0);

// Unmapped offset
add_row("unmapped write",       OP_WRITE, 8'h10, 32'hDEAD_BEEF, 32'h0000_0000, 0);
add_row("unmapped read",        OP_READ,  8'h10, 32'h0000_0000, 32'h0000_0000, 0);

// Write response held off by the master
add_row("stalled write",        OP_WRITE, 8'h00, 32'h8765_4321, 32'h8765_4321, 5);
add_row("write after stall",    OP_WRITE, 8'h08, 32'h0F0F_0F0F, 32'h0F0F_0F0F, 0);
add_row("tri2 after stall",     OP_READ,  8'h0C, 32'h0000_0000, 32'h00FF_00FF, 0);
add_row("input after stall",    OP_READ,  8'h00, 32'h0000_0000, GPIO1_PATTERN, 0);

/* dv/axil_gpio_tb.sv */
// One bus operation at a time; gpio inputs stay constant for the whole run, gpio2 from a seeded $random
`timescale 1ns/1ps

module axil_gpio_tb
	import gpio_pkg::*;
();

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} op_e;

	typedef struct packed {
		op_e        op;
		logic [7:0] ofs;
		gpio_word_t wdata;
		gpio_word_t exp_word;
		logic [7:0] b_delay;
	} test_row_t;

	localparam gpio_word_t GPIO1_PATTERN = 32'hA5C3_0F96;

	logic       clk;
	logic       rst_n;
	axil_addr_t awaddr;
	logic       awvalid;
	logic       awready;
	gpio_word_t wdata;
	logic       wvalid;
	logic       wready;
	axil_resp_e bresp;
	logic       bvalid;
	logic       bready;
	axil_addr_t araddr;
	logic       arvalid;
	logic       arready;
	gpio_word_t rdata;
	axil_resp_e rresp;
	logic       rvalid;
	logic       rready;
	gpio_word_t gpio_in;
	gpio_word_t gpio2_in;
	gpio_port_t gpio_out;
	gpio_port_t gpio2_out;

	test_row_t  rows[$];
	string      row_names[$];
	gpio_port_t exp_gpio;
	gpio_port_t exp_gpio2;
	gpio_word_t gpio2_val;
	integer     seed;
	int         cycle_count;
	int         cycle_limit;

	axil_gpio i_axil_gpio (
		.clk             (clk),
		.rst_n           (rst_n),
		.s_axi_awaddr_i  (awaddr),
		.s_axi_awvalid_i (awvalid),
		.s_axi_awready_o (awready),
		.s_axi_wdata_i   (wdata),
		.s_axi_wvalid_i  (wvalid),
		.s_axi_wready_o  (wready),
		.s_axi_bresp_o   (bresp),
		.s_axi_bvalid_o  (bvalid),
		.s_axi_bready_i  (bready),
		.s_axi_araddr_i  (araddr),
		.s_axi_arvalid_i (arvalid),
		.s_axi_arready_o (arready),
		.s_axi_rdata_o   (rdata),
		.s_axi_rresp_o   (rresp),
		.s_axi_rvalid_o  (rvalid),
		.s_axi_rready_i  (rready),
		.gpio_i          (gpio_in),
		.gpio2_i         (gpio2_in),
		.gpio_o          (gpio_out),
		.gpio2_o         (gpio2_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_failure();
		$display("Test failed");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	task automatic check_word(input string name, input gpio_word_t exp, input gpio_word_t act);
		if (exp !== act) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_port(input string name, input gpio_port_t exp, input gpio_port_t act);
		if (exp !== act) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
		if (exp !== act) begin
			$display("Error %s: expected %h, actual %h", name, exp, act);
			report_failure();
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Error %s: expected %b, actual %b", name, exp, act);
			report_failure();
		end
	endtask

	task automatic add_row(input string name, input op_e op, input logic [7:0] ofs,
			input gpio_word_t wr_word, input gpio_word_t exp_word, input int b_delay);
		rows.push_back('{op: op, ofs: ofs, wdata: wr_word, exp_word: exp_word,
			b_delay: b_delay[7:0]});
		row_names.push_back(name);
	endtask

	task automatic load_table();
		`include "gpio_test_table.svh"
	endtask

	// Address, data, then a response held off for b_delay cycles
	task automatic write_reg(input string name, input logic [7:0] ofs, input gpio_word_t word,
			input int b_delay, output axil_resp_e resp);
		@(negedge clk);
		awaddr  = {24'h0, ofs};
		awvalid = 1'b1;
		do @(posedge clk); while (!awready);
		@(negedge clk);
		awvalid = 1'b0;
		wdata   = word;
		wvalid  = 1'b1;
		do @(posedge clk); while (!wready);
		@(negedge clk);
		wvalid = 1'b0;
		while (!bvalid) @(negedge clk);
		for (int i = 0; i < b_delay; i++) begin
			check_level({name, " bvalid held"}, 1'b1, bvalid);
			check_level({name, " awready held low"}, 1'b0, awready);
			@(negedge clk);
		end
		resp   = bresp;
		bready = 1'b1;
		do @(posedge clk); while (!bvalid);
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] ofs, output gpio_word_t word,
			output axil_resp_e resp);
		@(negedge clk);
		araddr  = {24'h0, ofs};
		arvalid = 1'b1;
		do @(posedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid) @(negedge clk);
		word   = rdata;
		resp   = rresp;
		rready = 1'b1;
		do @(posedge clk); while (!rvalid);
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic run_row(input int idx);
		test_row_t  row;
		string      name;
		gpio_word_t rd_word;
		axil_resp_e resp;
		row  = rows[idx];
		name = row_names[idx];
		if (row.op == OP_WRITE) begin
			write_reg(name, row.ofs, row.wdata, row.b_delay, resp);
			check_resp({name, " bresp"}, RESP_OKAY, resp);
			// Unmapped offsets leave both ports alone
			case (row.ofs)
				8'h00: exp_gpio.data = row.exp_word;
				8'h04: exp_gpio.tristate = row.exp_word;
				8'h08: exp_gpio2.data = row.exp_word;
				8'h0C: exp_gpio2.tristate = row.exp_word;
				default: begin
				end
			endcase
			// Data pins lag the register by one cycle
			@(negedge clk);
			check_port({name, " gpio_o"}, exp_gpio, gpio_out);
			check_port({name, " gpio2_o"}, exp_gpio2, gpio2_out);
		end else begin
			read_reg(row.ofs, rd_word, resp);
			check_word({name, " rdata"}, row.exp_word, rd_word);
			check_resp({name, " rresp"}, RESP_OKAY, resp);
		end
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			report_failure();
		end
	end

	initial begin
		seed        = 40771;
		cycle_count = 0;
		cycle_limit = 0;
		rst_n       = 1'b0;
		awaddr      = '0;
		awvalid     = 1'b0;
		wdata       = '0;
		wvalid      = 1'b0;
		bready      = 1'b0;
		araddr      = '0;
		arvalid     = 1'b0;
		rready      = 1'b0;
		gpio2_val   = $random(seed);
		gpio_in     = GPIO1_PATTERN;
		gpio2_in    = gpio2_val;
		exp_gpio    = '{data: 32'h0000_000F, tristate: 32'hFFFF_FFFF};
		exp_gpio2   = '{data: 32'h0000_0000, tristate: 32'hFFFF_FFFF};
		load_table();
		cycle_limit = 40 * rows.size() + 100;

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_level("reset awready", 1'b1, awready);
		check_level("reset arready", 1'b1, arready);
		check_level("reset wready", 1'b0, wready);
		check_level("reset bvalid", 1'b0, bvalid);
		check_level("reset rvalid", 1'b0, rvalid);
		check_port("reset gpio_o", exp_gpio, gpio_out);
		check_port("reset gpio2_o", exp_gpio2, gpio2_out);

		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

/* hdl/axil_gpio.sv */
// AXI-Lite GPIO slave with two channels; only address bits 7:0 are decoded, so the map repeats
`timescale 1ns/1ps

module axil_gpio
	import gpio_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  axil_addr_t s_axi_awaddr_i,
	input  logic       s_axi_awvalid_i,
	output logic       s_axi_awready_o,

	input  gpio_word_t s_axi_wdata_i,
	input  logic       s_axi_wvalid_i,
	output logic       s_axi_wready_o,

	output axil_resp_e s_axi_bresp_o,
	output logic       s_axi_bvalid_o,
	input  logic       s_axi_bready_i,

	input  axil_addr_t s_axi_araddr_i,
	input  logic       s_axi_arvalid_i,
	output logic       s_axi_arready_o,

	output gpio_word_t s_axi_rdata_o,
	output axil_resp_e s_axi_rresp_o,
	output logic       s_axi_rvalid_o,
	input  logic       s_axi_rready_i,

	input  gpio_word_t gpio_i,
	input  gpio_word_t gpio2_i,
	output gpio_port_t gpio_o,
	output gpio_port_t gpio2_o
);

	reg_wr_t    reg_wr;
	reg_ofs_e   rd_ofs;
	gpio_word_t rd_data;

	axil_gpio_wr i_axil_gpio_wr (
		.clk       (clk),
		.rst_n     (rst_n),
		.awaddr_i  (s_axi_awaddr_i),
		.awvalid_i (s_axi_awvalid_i),
		.awready_o (s_axi_awready_o),
		.wdata_i   (s_axi_wdata_i),
		.wvalid_i  (s_axi_wvalid_i),
		.wready_o  (s_axi_wready_o),
		.bresp_o   (s_axi_bresp_o),
		.bvalid_o  (s_axi_bvalid_o),
		.bready_i  (s_axi_bready_i),
		.reg_wr_o  (reg_wr)
	);

	axil_gpio_rd i_axil_gpio_rd (
		.clk       (clk),
		.rst_n     (rst_n),
		.araddr_i  (s_axi_araddr_i),
		.arvalid_i (s_axi_arvalid_i),
		.arready_o (s_axi_arready_o),
		.rdata_o   (s_axi_rdata_o),
		.rresp_o   (s_axi_rresp_o),
		.rvalid_o  (s_axi_rvalid_o),
		.rready_i  (s_axi_rready_i),
		.rd_ofs_o  (rd_ofs),
		.rd_data_i (rd_data)
	);

	gpio_regs i_gpio_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.reg_wr_i  (reg_wr),
		.rd_ofs_i  (rd_ofs),
		.rd_data_o (rd_data),
		.gpio_i    (gpio_i),
		.gpio2_i   (gpio2_i),
		.gpio_o    (gpio_o),
		.gpio2_o   (gpio2_o)
	);

endmodule

/* hdl/axil_gpio_rd.sv */
// One read in flight; the register bank word is captured on the address handshake
`timescale 1ns/1ps

module axil_gpio_rd
	import gpio_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  axil_addr_t araddr_i,
	input  logic       arvalid_i,
	output logic       arready_o,

	output gpio_word_t rdata_o,
	output axil_resp_e rresp_o,
	output logic       rvalid_o,
	input  logic       rready_i,

	output reg_ofs_e   rd_ofs_o,
	input  gpio_word_t rd_data_i
);

	rd_state_e  state_q;
	gpio_word_t rdata_q;
	logic       ar_hs;
	logic       r_hs;

	assign arready_o = (state_q == RD_IDLE);
	assign rvalid_o  = (state_q == RD_RESP);
	assign rresp_o   = RESP_OKAY;
	assign rdata_o   = rdata_q;

	// Decode runs on the live address
	assign rd_ofs_o = reg_ofs_e'(araddr_i[REG_OFS_W-1:0]);

	assign ar_hs = arvalid_i && arready_o;
	assign r_hs  = rvalid_o && rready_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= RD_IDLE;
		end else begin
			case (state_q)
				RD_IDLE: begin
					if (ar_hs) begin
						state_q <= RD_RESP;
					end
				end
				RD_RESP: begin
					if (r_hs) begin
						state_q <= RD_IDLE;
					end
				end
				default: begin
					state_q <= RD_IDLE;
				end
			endcase
		end
	end

	// Word stays put while rvalid waits for rready
	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata_q <= rd_data_i;
		end
	end

endmodule

/* hdl/axil_gpio_wr.sv */
// One write in flight; address must come before data, wstrb is not supported, response is always OKAY
`timescale 1ns/1ps

module axil_gpio_wr
	import gpio_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  axil_addr_t awaddr_i,
	input  logic       awvalid_i,
	output logic       awready_o,

	input  gpio_word_t wdata_i,
	input  logic       wvalid_i,
	output logic       wready_o,

	output axil_resp_e bresp_o,
	output logic       bvalid_o,
	input  logic       bready_i,

	output reg_wr_t    reg_wr_o
);

	wr_state_e  state_q;
	logic       wr_en_q;
	reg_ofs_e   wr_ofs_q;
	gpio_word_t wr_data_q;
	logic       aw_hs;
	logic       w_hs;
	logic       b_hs;

	assign awready_o = (state_q == WR_IDLE);
	assign wready_o  = (state_q == WR_DATA);
	// Response rises together with the register update
	assign bvalid_o  = (state_q == WR_RESP) && !wr_en_q;
	assign bresp_o   = RESP_OKAY;

	assign aw_hs = awvalid_i && awready_o;
	assign w_hs  = wvalid_i && wready_o;
	assign b_hs  = bvalid_o && bready_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= WR_IDLE;
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= w_hs;
			case (state_q)
				WR_IDLE: begin
					if (aw_hs) begin
						state_q <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (w_hs) begin
						state_q <= WR_RESP;
					end
				end
				WR_RESP: begin
					// Hold off the next address until the master takes the response
					if (b_hs) begin
						state_q <= WR_IDLE;
					end
				end
				default: begin
					state_q <= WR_IDLE;
				end
			endcase
		end
	end

	// Offset and data of the pending write
	always_ff @(posedge clk) begin
		if (aw_hs) begin
			wr_ofs_q <= reg_ofs_e'(awaddr_i[REG_OFS_W-1:0]);
		end
		if (w_hs) begin
			wr_data_q <= wdata_i;
		end
	end

	assign reg_wr_o = '{en: wr_en_q, ofs: wr_ofs_q, data: wr_data_q};

endmodule

/* hdl/gpio_pkg.sv */
// Fixes all widths and reset values; only offsets 0x00 to 0x0C are mapped and every response is OKAY
package gpio_pkg;

	localparam int AXIL_ADDR_W = 32;
	localparam int GPIO_W      = 32;
	// Low address bits that take part in the register decode
	localparam int REG_OFS_W   = 8;

	localparam logic [GPIO_W-1:0] GPIO_RESET_DATA  = 32'h0000_000F;
	localparam logic [GPIO_W-1:0] GPIO_RESET_TRI   = 32'hFFFF_FFFF;
	localparam logic [GPIO_W-1:0] GPIO2_RESET_DATA = 32'h0000_0000;
	localparam logic [GPIO_W-1:0] GPIO2_RESET_TRI  = 32'hFFFF_FFFF;

	typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
	typedef logic [GPIO_W-1:0]      gpio_word_t;

	// Register map
	typedef enum logic [REG_OFS_W-1:0] {
		REG_GPIO_DATA  = 8'h00,
		REG_GPIO_TRI   = 8'h04,
		REG_GPIO2_DATA = 8'h08,
		REG_GPIO2_TRI  = 8'h0C
	} reg_ofs_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	typedef enum logic {
		RD_IDLE,
		RD_RESP
	} rd_state_e;

	// One-cycle write request into the register bank
	typedef struct packed {
		logic       en;
		reg_ofs_e   ofs;
		gpio_word_t data;
	} reg_wr_t;

	// Tristate bit high means the pin is an input
	typedef struct packed {
		gpio_word_t data;
		gpio_word_t tristate;
	} gpio_port_t;

endpackage

/* hdl/gpio_regs.sv */
// Inputs are sampled by one flop each with no synchronizer; writes to unmapped offsets are dropped
`timescale 1ns/1ps

module gpio_regs
	import gpio_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	input  reg_wr_t    reg_wr_i,

	input  reg_ofs_e   rd_ofs_i,
	output gpio_word_t rd_data_o,

	input  gpio_word_t gpio_i,
	input  gpio_word_t gpio2_i,
	output gpio_port_t gpio_o,
	output gpio_port_t gpio2_o
);

	// Programmed data and tristate per channel
	gpio_port_t port_q;
	gpio_port_t port2_q;

	// Output stage for the data pins
	gpio_word_t out_q;
	gpio_word_t out2_q;

	// Sampled inputs
	gpio_word_t in_q;
	gpio_word_t in2_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			port_q  <= '{data: GPIO_RESET_DATA, tristate: GPIO_RESET_TRI};
			port2_q <= '{data: GPIO2_RESET_DATA, tristate: GPIO2_RESET_TRI};
		end else if (reg_wr_i.en) begin
			case (reg_wr_i.ofs)
				REG_GPIO_DATA: begin
					port_q.data <= reg_wr_i.data;
				end
				REG_GPIO_TRI: begin
					port_q.tristate <= reg_wr_i.data;
				end
				REG_GPIO2_DATA: begin
					port2_q.data <= reg_wr_i.data;
				end
				REG_GPIO2_TRI: begin
					port2_q.tristate <= reg_wr_i.data;
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_q  <= GPIO_RESET_DATA;
			out2_q <= GPIO2_RESET_DATA;
		end else begin
			out_q  <= port_q.data;
			out2_q <= port2_q.data;
		end
	end

	always_ff @(posedge clk) begin
		in_q  <= gpio_i;
		in2_q <= gpio2_i;
	end

	// Data pins lag the register by a cycle, tristate does not
	assign gpio_o  = '{data: out_q, tristate: port_q.tristate};
	assign gpio2_o = '{data: out2_q, tristate: port2_q.tristate};

	// Data offsets read back the pins, not the programmed value
	always_comb begin
		case (rd_ofs_i)
			REG_GPIO_DATA: begin
				rd_data_o = in_q;
			end
			REG_GPIO_TRI: begin
				rd_data_o = port_q.tristate;
			end
			REG_GPIO2_DATA: begin
				rd_data_o = in2_q;
			end
			REG_GPIO2_TRI: begin
				rd_data_o = port2_q.tristate;
			end
			default: begin
				rd_data_o = '0;
			end
		endcase
	end

endmodule

/* tb.f */
+incdir+dv
hdl/gpio_pkg.sv
hdl/axil_gpio_wr.sv
hdl/axil_gpio_rd.sv
hdl/gpio_regs.sv
hdl/axil_gpio.sv
dv/axil_gpio_tb.sv
